// File: design/rs_cfg.svh
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Issue queue entries
`define RS_DEPTH 4

// Physical register file size and tag width
`define PREG_COUNT 32
`define PREG_W 5

// Operation id chosen by the front end
`define OP_ID_W 4

// Execution latency, 1 to 15 cycles
`define LAT_W 4

// Saturating age of a queue entry
`define AGE_W 3

`endif

// File: design/rs_pkg.sv
`include "rs_cfg.svh"

package rs_pkg;

    // Tags and small fields
    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`OP_ID_W-1:0] op_id_t;
    typedef logic [`LAT_W-1:0] lat_t;
    typedef logic [`AGE_W-1:0] age_t;

    typedef enum logic {
        ALU  = 1'b0,
        LOAD = 1'b1
    } op_kind_t;

    // Four-phase dispatch handshake
    typedef enum logic [1:0] {
        DS_IDLE     = 2'd0,
        DS_ACK      = 2'd1,
        DS_WAIT_LOW = 2'd2
    } dispatch_state_t;

    // Operation as presented by the front end
    typedef struct packed {
        op_id_t   op_id;
        op_kind_t kind;
        preg_t    src1;
        preg_t    src2;
        preg_t    dest;
        lat_t     latency;
    } dispatch_op_t;

    // What the execution unit needs from a queue entry
    typedef struct packed {
        op_id_t op_id;
        preg_t  dest;
        lat_t   latency;
    } issue_op_t;

    typedef struct packed {
        preg_t  dest;
        op_id_t op_id;
    } cdb_t;

endpackage

// File: design/preg_ready_table.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module preg_ready_table (
    input  logic          clk,
    input  logic          reset,
    input  logic          claim_valid,
    input  rs_pkg::preg_t claim_tag,
    input  rs_pkg::preg_t src1,
    input  rs_pkg::preg_t src2,
    output logic          src1_ready,
    output logic          src2_ready,
    input  logic          wakeup_valid,
    input  rs_pkg::preg_t wakeup_tag,
    input  logic          cdb_valid,
    input  rs_pkg::cdb_t  cdb
);

    // One bit per physical register, set means the value is available
    logic [`PREG_COUNT-1:0] ready;
    logic [`PREG_COUNT-1:0] set_mask;
    logic [`PREG_COUNT-1:0] clear_mask;

    // Decode the two set sources and the claim into masks
    always_comb begin
        set_mask   = '0;
        clear_mask = '0;
        if (wakeup_valid) begin
            set_mask[wakeup_tag] = 1'b1;
        end
        if (cdb_valid) begin
            set_mask[cdb.dest] = 1'b1;
        end
        if (claim_valid) begin
            clear_mask[claim_tag] = 1'b1;
        end
    end

    // Lookups see a set arriving in the same cycle
    assign src1_ready = ready[src1] | set_mask[src1];
    assign src2_ready = ready[src2] | set_mask[src2];

    // Claim applied last so it wins over a same-cycle set
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready <= '1;
        end else begin
            ready <= (ready | set_mask) & ~clear_mask;
        end
    end

endmodule

// File: design/issue_queue.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module issue_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc_valid,
    input  rs_pkg::dispatch_op_t alloc_op,
    input  logic                 src1_ready,
    input  logic                 src2_ready,
    input  logic                 wakeup_valid,
    input  rs_pkg::preg_t        wakeup_tag,
    input  logic                 cdb_valid,
    input  rs_pkg::cdb_t         cdb,
    input  logic                 unit_free,
    output logic                 queue_full,
    output logic                 issue_valid,
    output rs_pkg::issue_op_t    issue_op
);

    // Per-entry state
    logic [`RS_DEPTH-1:0] valid;
    logic [`RS_DEPTH-1:0] rdy1;
    logic [`RS_DEPTH-1:0] rdy2;
    rs_pkg::preg_t        src1_tag [`RS_DEPTH];
    rs_pkg::preg_t        src2_tag [`RS_DEPTH];
    rs_pkg::age_t         age [`RS_DEPTH];
    rs_pkg::issue_op_t    payload [`RS_DEPTH];

    // Tag match against the broadcasts of this cycle
    logic [`RS_DEPTH-1:0] wake1;
    logic [`RS_DEPTH-1:0] wake2;

    logic         alloc_fire;
    int           free_idx;
    logic         sel_found;
    int           sel_idx;
    rs_pkg::age_t sel_age;

    assign queue_full = &valid;
    assign alloc_fire = alloc_valid && !queue_full;

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wake1[i] = (wakeup_valid && wakeup_tag == src1_tag[i])
                    || (cdb_valid && cdb.dest == src1_tag[i]);
            wake2[i] = (wakeup_valid && wakeup_tag == src2_tag[i])
                    || (cdb_valid && cdb.dest == src2_tag[i]);
        end
    end

    // Lowest free slot, scanned from the top so the last hit wins
    always_comb begin
        free_idx = 0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = i;
            end
        end
    end

    // Oldest ready entry; strict compare keeps the lowest index on a tie
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = 0;
        sel_age   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i] && (!sel_found || age[i] > sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = i;
                sel_age   = age[i];
            end
        end
    end

    assign issue_valid = unit_free && sel_found;
    assign issue_op    = payload[sel_idx];

    // Slot occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[sel_idx] <= 1'b0;
            end
            if (alloc_fire) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    // Source readiness, age and contents
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (valid[i]) begin
                if (wake1[i]) begin
                    rdy1[i] <= 1'b1;
                end
                if (wake2[i]) begin
                    rdy2[i] <= 1'b1;
                end
                // Older entries step up one on every allocation
                if (alloc_fire && age[i] != '1) begin
                    age[i] <= age[i] + rs_pkg::age_t'(1);
                end
            end
        end
        if (alloc_fire) begin
            src1_tag[free_idx] <= alloc_op.src1;
            src2_tag[free_idx] <= alloc_op.src2;
            rdy1[free_idx]     <= src1_ready;
            rdy2[free_idx]     <= src2_ready;
            age[free_idx]      <= '0;
            payload[free_idx]  <= '{op_id:   alloc_op.op_id,
                                   dest:    alloc_op.dest,
                                   latency: alloc_op.latency};
        end
    end

endmodule

// File: design/dispatch_ctrl.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module dispatch_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_req,
    input  rs_pkg::dispatch_op_t dispatch_op,
    input  logic                 queue_full,
    output logic                 dispatch_ack,
    output logic                 alloc_valid,
    output rs_pkg::dispatch_op_t alloc_op,
    output logic                 claim_valid,
    output rs_pkg::preg_t        claim_tag
);

    rs_pkg::dispatch_state_t state;
    rs_pkg::dispatch_state_t state_next;
    logic                    accept;
    logic                    is_load;

    assign is_load = (dispatch_op.kind == rs_pkg::LOAD);

    // A load never enters the queue, so a full queue only stalls ALU ops
    assign accept = (state == rs_pkg::DS_IDLE) && dispatch_req
                 && (!queue_full || is_load);

    always_comb begin
        state_next = state;
        case (state)
            rs_pkg::DS_IDLE: begin
                if (accept) begin
                    state_next = rs_pkg::DS_ACK;
                end
            end
            // Hold ack until the front end lets go of req
            rs_pkg::DS_ACK: begin
                if (!dispatch_req) begin
                    state_next = rs_pkg::DS_WAIT_LOW;
                end
            end
            // Ack back at zero, one cycle before the next req is sampled
            rs_pkg::DS_WAIT_LOW: begin
                state_next = rs_pkg::DS_IDLE;
            end
            default: begin
                state_next = rs_pkg::DS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rs_pkg::DS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign dispatch_ack = (state == rs_pkg::DS_ACK);

    // Single-cycle write strobes on the accepting edge
    assign claim_valid = accept;
    assign claim_tag   = dispatch_op.dest;
    assign alloc_valid = accept && !is_load;
    assign alloc_op    = dispatch_op;

endmodule

// File: design/exec_timer.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module exec_timer (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  rs_pkg::issue_op_t issue_op,
    output logic              unit_free,
    output logic              cdb_valid,
    output rs_pkg::cdb_t      cdb
);

    logic         busy;
    rs_pkg::lat_t count;
    logic         accept;

    // No new op while one is in flight or its result is on the bus
    assign unit_free = !busy && !cdb_valid;
    assign accept    = issue_valid && unit_free;

    // Down-counter, result broadcast when it reaches one
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            count     <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                count <= issue_op.latency;
            end else if (busy) begin
                // Also catches a zero latency, treated as one
                if (count <= rs_pkg::lat_t'(1)) begin
                    busy      <= 1'b0;
                    cdb_valid <= 1'b1;
                end else begin
                    count <= count - rs_pkg::lat_t'(1);
                end
            end
        end
    end

    // Result tag captured at issue and held until the next op
    always_ff @(posedge clk) begin
        if (accept) begin
            cdb.dest  <= issue_op.dest;
            cdb.op_id <= issue_op.op_id;
        end
    end

endmodule

// File: design/rs_top.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_req,
    input  rs_pkg::dispatch_op_t dispatch_op,
    output logic                 dispatch_ack,
    input  logic                 wakeup_valid,
    input  rs_pkg::preg_t        wakeup_tag,
    output logic                 cdb_valid,
    output rs_pkg::cdb_t         cdb,
    output logic                 rs_full
);

    // Dispatch to queue and table
    logic                 alloc_valid;
    rs_pkg::dispatch_op_t alloc_op;
    logic                 claim_valid;
    rs_pkg::preg_t        claim_tag;
    logic                 src1_ready;
    logic                 src2_ready;

    // Queue to execution unit
    logic                 issue_valid;
    rs_pkg::issue_op_t    issue_op;
    logic                 unit_free;

    dispatch_ctrl u_dispatch_ctrl (
        .clk          (clk),
        .reset        (reset),
        .dispatch_req (dispatch_req),
        .dispatch_op  (dispatch_op),
        .queue_full   (rs_full),
        .dispatch_ack (dispatch_ack),
        .alloc_valid  (alloc_valid),
        .alloc_op     (alloc_op),
        .claim_valid  (claim_valid),
        .claim_tag    (claim_tag)
    );

    preg_ready_table u_preg_ready_table (
        .clk          (clk),
        .reset        (reset),
        .claim_valid  (claim_valid),
        .claim_tag    (claim_tag),
        .src1         (alloc_op.src1),
        .src2         (alloc_op.src2),
        .src1_ready   (src1_ready),
        .src2_ready   (src2_ready),
        .wakeup_valid (wakeup_valid),
        .wakeup_tag   (wakeup_tag),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb)
    );

    issue_queue u_issue_queue (
        .clk          (clk),
        .reset        (reset),
        .alloc_valid  (alloc_valid),
        .alloc_op     (alloc_op),
        .src1_ready   (src1_ready),
        .src2_ready   (src2_ready),
        .wakeup_valid (wakeup_valid),
        .wakeup_tag   (wakeup_tag),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb),
        .unit_free    (unit_free),
        .queue_full   (rs_full),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op)
    );

    exec_timer u_exec_timer (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .unit_free    (unit_free),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb)
    );

endmodule

// File: testbench/rs_chk.sv
`timescale 1ns/1ps

module rs_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 dispatch_req,
    input rs_pkg::dispatch_op_t dispatch_op,
    input logic                 dispatch_ack,
    input logic                 cdb_valid,
    input logic                 rs_full
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Ack only answers a request that was pending on the accepting edge
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(dispatch_ack) |-> $past(dispatch_req))
    else begin
        fail_count++;
        $error("dispatch_ack rose without dispatch_req");
    end

    ack_holds: assert property (@(posedge clk) disable iff (reset)
        dispatch_ack && dispatch_req |=> dispatch_ack)
    else begin
        fail_count++;
        $error("dispatch_ack fell while dispatch_req was still high");
    end

    // One result per completion, never back to back
    cdb_single: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |=> !cdb_valid)
    else begin
        fail_count++;
        $error("cdb_valid high two cycles in a row");
    end

    alu_not_full: assert property (@(posedge clk) disable iff (reset)
        $rose(dispatch_ack) && dispatch_op.kind == rs_pkg::ALU |-> !$past(rs_full))
    else begin
        fail_count++;
        $error("ALU op acknowledged while the queue was full");
    end

endmodule

bind rs_top rs_chk u_rs_chk (
    .clk          (clk),
    .reset        (reset),
    .dispatch_req (dispatch_req),
    .dispatch_op  (dispatch_op),
    .dispatch_ack (dispatch_ack),
    .cdb_valid    (cdb_valid),
    .rs_full      (rs_full)
);

// File: testbench/rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

    localparam int CLK_HALF = 10;
    // 16 cycles per dispatched op over 40 ops, plus margin
    localparam int WATCHDOG_CYCLES = 16 * 40 + 200;

    logic                 clk;
    logic                 reset;
    logic                 dispatch_req;
    rs_pkg::dispatch_op_t dispatch_op;
    logic                 dispatch_ack;
    logic                 wakeup_valid;
    rs_pkg::preg_t        wakeup_tag;
    logic                 cdb_valid;
    rs_pkg::cdb_t         cdb;
    logic                 rs_full;

    rs_pkg::cdb_t cdb_log[$];
    int           errors;
    int           test_errors;
    int           tests_passed;
    int           tests_failed;

    rs_top dut (
        .clk          (clk),
        .reset        (reset),
        .dispatch_req (dispatch_req),
        .dispatch_op  (dispatch_op),
        .dispatch_ack (dispatch_ack),
        .wakeup_valid (wakeup_valid),
        .wakeup_tag   (wakeup_tag),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb),
        .rs_full      (rs_full)
    );

    always #CLK_HALF clk = ~clk;

    // Results in broadcast order
    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            cdb_log.push_back(cdb);
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic complain(input string what);
        $display("%s", what);
        test_errors++;
    endtask

    function automatic int rand_lat();
        return 1 + int'($urandom % 15);
    endfunction

    function automatic rs_pkg::dispatch_op_t make_op(input int id, input rs_pkg::op_kind_t kind,
                                                     input int s1, input int s2,
                                                     input int d, input int lat);
        rs_pkg::dispatch_op_t op;
        op.op_id   = rs_pkg::op_id_t'(id);
        op.kind    = kind;
        op.src1    = rs_pkg::preg_t'(s1);
        op.src2    = rs_pkg::preg_t'(s2);
        op.dest    = rs_pkg::preg_t'(d);
        op.latency = rs_pkg::lat_t'(lat);
        return op;
    endfunction

    task automatic raise_req(input rs_pkg::dispatch_op_t op);
        @(negedge clk);
        dispatch_op  = op;
        dispatch_req = 1'b1;
    endtask

    // Returns on the falling edge where ack is seen, or after limit cycles
    task automatic wait_ack(input int limit, output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = dispatch_ack;
            n++;
        end
    endtask

    task automatic drop_req(input string name);
        int n;
        n = 0;
        // Front end keeps req up one more cycle after it sees ack
        @(negedge clk);
        dispatch_req = 1'b0;
        while (dispatch_ack && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (dispatch_ack) begin
            complain($sformatf("%s: dispatch_ack stayed high after req dropped", name));
        end
    endtask

    task automatic dispatch(input string name, input rs_pkg::dispatch_op_t op);
        bit seen;
        raise_req(op);
        wait_ack(40, seen);
        if (!seen) begin
            complain($sformatf("%s: op %0d was never acknowledged", name, op.op_id));
        end
        drop_req(name);
    endtask

    task automatic wake(input int tag);
        @(negedge clk);
        wakeup_valid = 1'b1;
        wakeup_tag   = rs_pkg::preg_t'(tag);
        @(negedge clk);
        wakeup_valid = 1'b0;
    endtask

    task automatic wait_results(input string name, input int count, input int limit);
        int n;
        n = 0;
        while (cdb_log.size() < count && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (cdb_log.size() < count) begin
            complain($sformatf("%s: only %0d of %0d results arrived on the CDB",
                               name, cdb_log.size(), count));
        end
    endtask

    task automatic check_result(input string name, input int idx, input int id, input int dest);
        if (idx >= cdb_log.size()) begin
            complain($sformatf("%s: result %0d never appeared on the CDB", name, idx));
        end else begin
            check({name, " op id"}, id, cdb_log[idx].op_id);
            check({name, " dest"}, dest, cdb_log[idx].dest);
        end
    endtask

    task automatic begin_test();
        @(posedge clk);
        cdb_log.delete();
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
    endtask

    // One unit, oldest first, so results follow dispatch order
    task automatic test_in_order();
        begin_test();
        for (int i = 0; i < 4; i++) begin
            dispatch("in_order", make_op(1 + i, rs_pkg::ALU, 0, 1, 10 + i, rand_lat()));
        end
        wait_results("in_order", 4, 4 * 20);
        for (int i = 0; i < 4; i++) begin
            check_result("in_order", i, 1 + i, 10 + i);
        end
        end_test("in_order");
    endtask

    task automatic test_dependency();
        begin_test();
        dispatch("dependency", make_op(5, rs_pkg::ALU, 0, 1, 14, 15));
        dispatch("dependency", make_op(6, rs_pkg::ALU, 14, 1, 15, 1));
        wait_results("dependency", 2, 60);
        check_result("dependency", 0, 5, 14);
        check_result("dependency", 1, 6, 15);
        end_test("dependency");
    endtask

    task automatic test_load_wakeup();
        begin_test();
        dispatch("load_wakeup", make_op(7, rs_pkg::LOAD, 0, 0, 16, 1));
        dispatch("load_wakeup", make_op(8, rs_pkg::ALU, 16, 0, 17, rand_lat()));
        repeat (20) @(posedge clk);
        check("load_wakeup results before wakeup", 0, cdb_log.size());
        wake(16);
        wait_results("load_wakeup", 1, 40);
        check_result("load_wakeup", 0, 8, 17);
        end_test("load_wakeup");
    endtask

    task automatic test_full_queue();
        bit seen;
        begin_test();
        dispatch("full_queue", make_op(9, rs_pkg::LOAD, 0, 0, 18, 1));
        for (int i = 0; i < 4; i++) begin
            dispatch("full_queue", make_op(10 + i, rs_pkg::ALU, 18, 1, 19 + i, rand_lat()));
        end
        @(negedge clk);
        check("full_queue rs_full", 1, rs_full);
        raise_req(make_op(14, rs_pkg::ALU, 0, 1, 23, rand_lat()));
        wait_ack(20, seen);
        check("full_queue ack while full", 0, seen);
        wake(18);
        wait_ack(40, seen);
        if (!seen) begin
            complain("full_queue: fifth op not acknowledged after wakeup");
        end
        drop_req("full_queue");
        wait_results("full_queue", 5, 5 * 20);
        for (int i = 0; i < 5; i++) begin
            check_result("full_queue", i, 10 + i, 19 + i);
        end
        end_test("full_queue");
    endtask

    task automatic test_overtake();
        begin_test();
        dispatch("overtake", make_op(1, rs_pkg::LOAD, 0, 0, 24, 1));
        dispatch("overtake", make_op(2, rs_pkg::ALU, 24, 0, 25, rand_lat()));
        dispatch("overtake", make_op(3, rs_pkg::ALU, 0, 1, 26, rand_lat()));
        wait_results("overtake", 1, 40);
        check_result("overtake", 0, 3, 26);
        wake(24);
        wait_results("overtake", 2, 40);
        check_result("overtake", 1, 2, 25);
        end_test("overtake");
    endtask

    task automatic test_reset();
        bit seen;
        begin_test();
        dispatch("reset", make_op(4, rs_pkg::LOAD, 0, 0, 27, 1));
        for (int i = 0; i < 3; i++) begin
            dispatch("reset", make_op(5 + i, rs_pkg::ALU, 27, 1, 28 + i, rand_lat()));
        end
        // Ready op goes straight to the unit and is still in flight at reset
        dispatch("reset", make_op(8, rs_pkg::ALU, 0, 1, 31, 15));
        dispatch("reset", make_op(9, rs_pkg::ALU, 27, 1, 26, rand_lat()));
        check("reset rs_full before reset", 1, rs_full);
        // A load is taken even with the queue full, so ack is up going into reset
        raise_req(make_op(10, rs_pkg::LOAD, 0, 0, 27, 1));
        wait_ack(20, seen);
        check("reset ack before reset", 1, seen);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset        = 1'b0;
        dispatch_req = 1'b0;
        check("reset dispatch_ack", 0, dispatch_ack);
        check("reset rs_full", 0, rs_full);
        repeat (20) @(posedge clk);
        check("reset results of flushed op", 0, cdb_log.size());
        dispatch("reset", make_op(11, rs_pkg::ALU, 0, 1, 28, rand_lat()));
        wait_results("reset", 1, 40);
        check_result("reset", 0, 11, 28);
        end_test("reset");
    endtask

    initial begin
        void'($urandom(32'h6fc1816e));
        clk          = 1'b0;
        reset        = 1'b1;
        dispatch_req = 1'b0;
        dispatch_op  = '0;
        wakeup_valid = 1'b0;
        wakeup_tag   = '0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        test_in_order();
        test_dependency();
        test_load_wakeup();
        test_full_queue();
        test_overtake();
        test_reset();
        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, dut.u_rs_chk.fail_count);
        if (errors == 0 && dut.u_rs_chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/rs_pkg.sv
design/preg_ready_table.sv
design/issue_queue.sv
design/dispatch_ctrl.sv
design/exec_timer.sv
design/rs_top.sv
testbench/rs_chk.sv
testbench/rs_tb.sv

// File: Bender.yml
package:
  name: rs_issue

sources:
  - include_dirs:
      - design
    files:
      - design/rs_pkg.sv
      - design/preg_ready_table.sv
      - design/issue_queue.sv
      - design/dispatch_ctrl.sv
      - design/exec_timer.sv
      - design/rs_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/rs_chk.sv
      - testbench/rs_tb.sv
